// File: hw/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Direct-mapped, one word per line
`define CACHE_LINES  256

`define CACHE_ADDR_W 32  // Byte address
`define CACHE_DATA_W 32

`endif

// File: hw/cache_pkg.sv
`default_nettype none
`include "cache_defs.svh"

package cache_pkg;

    localparam int OFFSET_W = $clog2(`CACHE_DATA_W / 8);  // Byte offset, ignored
    localparam int INDEX_W  = $clog2(`CACHE_LINES);
    localparam int TAG_W    = `CACHE_ADDR_W - INDEX_W - OFFSET_W;

    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;

    // Per-line bookkeeping, kept beside the data word
    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } line_meta_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITE_BACK,
        FETCH,
        FILL,
        FLUSH_SCAN,
        FLUSH_WRITE
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: hw/mem_bus_pkg.sv
`default_nettype none
`include "cache_defs.svh"

package mem_bus_pkg;

    // Word-wide main memory port
    typedef logic [`CACHE_ADDR_W-1:0] mem_addr_t;
    typedef logic [`CACHE_DATA_W-1:0] mem_word_t;

endpackage

`default_nettype wire

// File: hw/store_if.sv
`timescale 1ns/1ps
`default_nettype none

interface store_if;

    cache_pkg::index_t      index;
    cache_pkg::tag_t        lookup_tag;
    logic                   hit;
    cache_pkg::line_meta_t  victim_meta;  // Whatever sits at index now
    mem_bus_pkg::mem_word_t line_data;

    // Write port, same index as the read
    logic                   meta_we;
    cache_pkg::line_meta_t  meta_wdata;
    logic                   data_we;
    mem_bus_pkg::mem_word_t data_wdata;

    modport ctrl (
        output index, lookup_tag, meta_we, meta_wdata, data_we, data_wdata,
        input  hit, victim_meta, line_data
    );

    modport store (
        input  index, lookup_tag, meta_we, meta_wdata, data_we, data_wdata,
        output hit, victim_meta, line_data
    );

endinterface

`default_nettype wire

// File: hw/line_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module line_ram
    import cache_pkg::*;
#(
    parameter type entry_t = logic
) (
    input  logic   clk,
    input  logic   reset,
    input  index_t raddr,
    output entry_t rdata,
    input  logic   we,
    input  index_t waddr,
    input  entry_t wdata
);

    entry_t mem [`CACHE_LINES];

    assign rdata = mem[raddr];  // Asynchronous read

    // Clearing to zero leaves every metadata entry invalid
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `CACHE_LINES; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

endmodule

`default_nettype wire

// File: hw/cache_store.sv
`timescale 1ns/1ps
`default_nettype none

module cache_store
    import cache_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    store_if.store bus
);

    line_meta_t meta_rd;
    mem_word_t  data_rd;

    line_ram #(
        .entry_t (line_meta_t)
    ) meta_ram (
        .clk   (clk),
        .reset (reset),
        .raddr (bus.index),
        .rdata (meta_rd),
        .we    (bus.meta_we),
        .waddr (bus.index),
        .wdata (bus.meta_wdata)
    );

    line_ram #(
        .entry_t (mem_word_t)
    ) data_ram (
        .clk   (clk),
        .reset (reset),
        .raddr (bus.index),
        .rdata (data_rd),
        .we    (bus.data_we),
        .waddr (bus.index),
        .wdata (bus.data_wdata)
    );

    // Tag compare on the line at the current index
    assign bus.hit = meta_rd.valid && (meta_rd.tag == bus.lookup_tag);

    // Controller decides write-back from this on a miss or during flush
    assign bus.victim_meta = meta_rd;
    assign bus.line_data   = data_rd;

endmodule

`default_nettype wire

// File: hw/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module cache_ctrl
    import cache_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      read,
    input  logic      write,
    input  logic      flush,
    input  mem_addr_t address,
    input  mem_word_t write_data,
    output mem_word_t read_data,
    output logic      hit,
    output logic      miss,
    output logic      ready,
    output logic      mem_read,
    output logic      mem_write,
    output mem_addr_t mem_address,
    output mem_word_t mem_write_data,
    input  mem_word_t mem_read_data,
    store_if.ctrl     bus
);

    ctrl_state_e state;
    ctrl_state_e next_state;
    mem_addr_t   req_addr;
    mem_word_t   req_data;
    logic        req_write;
    index_t      req_index;
    tag_t        req_tag;
    index_t      flush_idx;
    logic        flushing;
    logic        victim_dirty;
    logic        last_line;
    logic        writing_back;

    assign req_index    = req_addr[OFFSET_W +: INDEX_W];
    assign req_tag      = req_addr[OFFSET_W + INDEX_W +: TAG_W];
    assign flushing     = (state == FLUSH_SCAN) || (state == FLUSH_WRITE);
    assign victim_dirty = bus.victim_meta.valid && bus.victim_meta.dirty;
    assign last_line    = (flush_idx == index_t'(`CACHE_LINES - 1));
    assign writing_back = (state == WRITE_BACK) || (state == FLUSH_WRITE);
    assign ready        = (state == IDLE);

    assign bus.index      = flushing ? flush_idx : req_index;
    assign bus.lookup_tag = req_tag;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (flush) begin
                    next_state = FLUSH_SCAN;  // Flush wins over read/write
                end else if (read || write) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                if (bus.hit) begin
                    next_state = IDLE;
                end else if (victim_dirty) begin
                    next_state = WRITE_BACK;
                end else begin
                    next_state = FETCH;
                end
            end
            WRITE_BACK:  next_state = FETCH;
            FETCH:       next_state = FILL;
            FILL:        next_state = IDLE;
            FLUSH_SCAN: begin
                if (victim_dirty) begin
                    next_state = FLUSH_WRITE;
                end else if (last_line) begin
                    next_state = IDLE;
                end
            end
            FLUSH_WRITE: next_state = last_line ? IDLE : FLUSH_SCAN;
            default:     next_state = IDLE;
        endcase
    end

    // Storage updates: write hit, line fill, dirty clear on flush
    always_comb begin
        bus.meta_we    = 1'b0;
        bus.data_we    = 1'b0;
        bus.meta_wdata = line_meta_t'{valid: 1'b1, dirty: req_write, tag: req_tag};
        bus.data_wdata = req_write ? req_data : mem_read_data;  // Write miss overrides fill
        case (state)
            LOOKUP: begin
                bus.meta_we = bus.hit && req_write;
                bus.data_we = bus.hit && req_write;
            end
            FILL: begin
                bus.meta_we = 1'b1;
                bus.data_we = 1'b1;
            end
            FLUSH_WRITE: begin
                bus.meta_we    = 1'b1;
                bus.meta_wdata = line_meta_t'{valid: 1'b1, dirty: 1'b0,
                                              tag: bus.victim_meta.tag};
            end
            default: ;
        endcase
    end

    always_comb begin
        mem_read       = (state == FETCH);
        mem_write      = writing_back;
        mem_write_data = bus.line_data;
        if (writing_back) begin
            mem_address = {bus.victim_meta.tag, bus.index, {OFFSET_W{1'b0}}};
        end else begin
            mem_address = {req_tag, req_index, {OFFSET_W{1'b0}}};
        end
    end

    // Request held here while the FSM works on it
    always_ff @(posedge clk) begin
        if (ready && !flush && (read || write)) begin
            req_addr  <= address;
            req_data  <= write_data;
            req_write <= write;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= IDLE;
            flush_idx <= '0;
            hit       <= 1'b0;
            miss      <= 1'b0;
            read_data <= '0;
        end else begin
            state <= next_state;
            case (state)
                IDLE: begin
                    if (flush || read || write) begin
                        hit       <= 1'b0;
                        miss      <= 1'b0;
                        flush_idx <= '0;
                    end
                end
                LOOKUP: begin
                    hit  <= bus.hit;
                    miss <= !bus.hit;
                    if (bus.hit && !req_write) begin
                        read_data <= bus.line_data;
                    end
                end
                FILL: begin
                    if (!req_write) begin
                        read_data <= mem_read_data;
                    end
                end
                FLUSH_SCAN: begin
                    if (!victim_dirty) begin
                        flush_idx <= flush_idx + 1'b1;  // Clean line, move on
                    end
                end
                FLUSH_WRITE: flush_idx <= flush_idx + 1'b1;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      read,
    input  logic      write,
    input  logic      flush,
    input  mem_addr_t address,
    input  mem_word_t write_data,
    output mem_word_t read_data,
    output logic      hit,
    output logic      miss,
    output logic      ready,
    output logic      mem_read,
    output logic      mem_write,
    output mem_addr_t mem_address,
    output mem_word_t mem_write_data,
    input  mem_word_t mem_read_data
);

    store_if store_bus ();

    cache_ctrl u_ctrl (
        .clk            (clk),
        .reset          (reset),
        .read           (read),
        .write          (write),
        .flush          (flush),
        .address        (address),
        .write_data     (write_data),
        .read_data      (read_data),
        .hit            (hit),
        .miss           (miss),
        .ready          (ready),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .mem_address    (mem_address),
        .mem_write_data (mem_write_data),
        .mem_read_data  (mem_read_data),
        .bus            (store_bus.ctrl)
    );

    cache_store u_store (
        .clk   (clk),
        .reset (reset),
        .bus   (store_bus.store)
    );

endmodule

`default_nettype wire

// File: verification/cache_chk.sv
`timescale 1ns/1ps
`default_nettype none

module cache_chk (
    input logic clk,
    input logic reset,
    input logic ready,
    input logic hit,
    input logic miss,
    input logic mem_read,
    input logic mem_write
);

    a_mem_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(mem_read && mem_write)) else $error("mem_read and mem_write high together");

    a_read_pulse: assert property (@(posedge clk) disable iff (reset)
        mem_read |=> !mem_read) else $error("mem_read held longer than one cycle");

    a_write_pulse: assert property (@(posedge clk) disable iff (reset)
        mem_write |=> !mem_write) else $error("mem_write held longer than one cycle");

    a_hit_miss: assert property (@(posedge clk) disable iff (reset)
        !(hit && miss)) else $error("hit and miss high together");

    // First edge out of reset
    a_ready_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> ready) else $error("ready low after reset");

endmodule

bind cache_top cache_chk u_chk (.*);

`default_nettype wire

// File: verification/tb_cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cache_top
    import mem_bus_pkg::*;
();

    localparam int READY_TIMEOUT = 2000;  // A flush of all dirty lines fits inside

    logic      clk = 1'b0;
    logic      reset = 1'b1;
    logic      read = 1'b0;
    logic      write = 1'b0;
    logic      flush = 1'b0;
    mem_addr_t address = '0;
    mem_word_t write_data = '0;
    mem_word_t read_data;
    logic      hit;
    logic      miss;
    logic      ready;
    logic      mem_read;
    logic      mem_write;
    mem_addr_t mem_address;
    mem_word_t mem_write_data;
    mem_word_t mem_read_data = '0;

    mem_word_t init_mem [4096];           // LFSR pattern that no write changes
    mem_word_t mem_model [logic [11:0]];  // Words written back by the cache
    int        read_count = 0;
    int        write_count = 0;

    always #2 clk = ~clk;

    cache_top dut (.*);

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic mem_word_t model_word(input logic [11:0] idx);
        if (mem_model.exists(idx)) begin
            return mem_model[idx];
        end
        return init_mem[idx];
    endfunction

    // Words indexed by address bits 13 to 2 and returned one cycle after mem_read
    always @(posedge clk) begin
        if (mem_read) begin
            mem_read_data <= model_word(mem_address[13:2]);
            read_count    <= read_count + 1;
        end
        if (mem_write) begin
            mem_model[mem_address[13:2]] = mem_write_data;
            write_count <= write_count + 1;
        end
    end

    task automatic fill_init_mem();
        logic [31:0] lfsr;
        mem_word_t   word;
        lfsr = 32'h553c_dfd0;
        word = '0;
        for (int i = 0; i < 4096; i++) begin
            for (int b = 0; b < 32; b++) begin
                lfsr = lfsr_next(lfsr);  // One step per bit
                word = {word[30:0], lfsr[0]};
            end
            init_mem[i] = word;
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "Run stopped on first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("FAILED at %0t ns: %s is %h, expected %h",
                                $time, what, got, expected));
        end
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (!ready) begin
            if (cycles == READY_TIMEOUT) begin
                abort_run("Timed out waiting for ready");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    // Strobe held for the one accepting edge
    task automatic run_op(input logic [7:0] op, input mem_addr_t addr, input mem_word_t data);
        address    = addr;
        write_data = data;
        flush      = (op == "F");
        read       = (op == "R");
        write      = (op == "W");
        @(negedge clk);
        flush = 1'b0;
        read  = 1'b0;
        write = 1'b0;
        wait_ready();
    endtask

    task automatic check_flags(input logic [7:0] hm);
        logic [1:0] exp_flags;
        exp_flags = 2'b00;
        case (hm)
            "H": exp_flags = 2'b10;
            "M": exp_flags = 2'b01;
            "N": exp_flags = 2'b00;
            default: abort_run($sformatf("Unknown hit/miss code '%c' in test file", hm));
        endcase
        check_value("hit,miss", 32'({hit, miss}), 32'(exp_flags));
    endtask

    initial begin
        int         fd;
        int         fields;
        int         ops;
        int         rd_exp;
        int         wr_exp;
        int         rd_start;
        int         wr_start;
        string      line;
        logic [7:0] op;
        logic [7:0] hm;
        logic [7:0] src;
        mem_addr_t  addr;
        mem_word_t  data;
        mem_word_t  expect_val;

        fill_init_mem();
        ops = 0;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_value("ready,hit,miss,mem_read,mem_write after reset",
                    32'({ready, hit, miss, mem_read, mem_write}), 32'h10);

        fd = $fopen("verification/cache_tests.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open verification/cache_tests.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%c %h %h %c %d %d %c %h",
                             op, addr, data, hm, rd_exp, wr_exp, src, expect_val);
            if (fields != 8) begin
                abort_run($sformatf("Malformed test line: %s", line));
            end
            ops++;
            if (op == "M") begin
                check_value($sformatf("memory word at %h", addr),
                            model_word(addr[13:2]), expect_val);
            end else begin
                if (op != "R" && op != "W" && op != "F") begin
                    abort_run($sformatf("Unknown operation '%c' in test file", op));
                end
                rd_start = read_count;
                wr_start = write_count;
                run_op(op, addr, data);
                check_flags(hm);
                check_value("mem_read pulses", 32'(read_count - rd_start), 32'(rd_exp));
                check_value("mem_write pulses", 32'(write_count - wr_start), 32'(wr_exp));
                if (src == "I") begin
                    check_value("read_data", read_data, init_mem[addr[13:2]]);
                end else if (src == "F") begin
                    check_value("read_data", read_data, expect_val);
                end
            end
        end
        $fclose(fd);
        if (ops == 0) begin
            abort_run("Test file held no operations");
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/cache_tests.txt
# op addr wdata hit/miss(H,M,N) mem_reads mem_writes read_src(I initial,F file,- none) expect
# M lines compare the memory model word at addr with expect
R 00000100 00000000 M 1 0 I 00000000
R 00000100 00000000 H 0 0 I 00000000
W 00000100 deadbeef H 0 0 - 00000000
R 00000100 00000000 H 0 0 F deadbeef
R 00000500 00000000 M 1 1 I 00000000
M 00000100 00000000 - 0 0 - deadbeef
R 00000100 00000000 M 1 0 F deadbeef
W 00000204 12345678 M 1 0 - 00000000
R 00000204 00000000 H 0 0 F 12345678
W 00000008 a5a50001 M 1 0 - 00000000
W 00000ffc 0badcafe M 1 0 - 00000000
W 00000100 5555aaaa H 0 0 - 00000000
F 00000000 00000000 N 0 4 - 00000000
M 00000204 00000000 - 0 0 - 12345678
M 00000008 00000000 - 0 0 - a5a50001
M 00000ffc 00000000 - 0 0 - 0badcafe
M 00000100 00000000 - 0 0 - 5555aaaa
F 00000000 00000000 N 0 0 - 00000000
R 00000ffc 00000000 H 0 0 F 0badcafe
R 00000100 00000000 H 0 0 F 5555aaaa
R 00000008 00000000 H 0 0 F a5a50001

// File: filelist.f
+incdir+hw
hw/cache_pkg.sv
hw/mem_bus_pkg.sv
hw/store_if.sv
hw/line_ram.sv
hw/cache_store.sv
hw/cache_ctrl.sv
hw/cache_top.sv
verification/cache_chk.sv
verification/tb_cache_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_cache_top \
    -f filelist.f \
    -Mdir obj_dir -o tb_cache_top

./obj_dir/tb_cache_top
